// File: hw/cpu_pkg.sv
/*
 * Shared types and constants for the reduced 900H style core.
 * Imported by the sequencer, the register bank, the ALU and the top level.
 * Instruction word layout is given by insn_t, control word by ucode_t.
 */
package cpu_pkg;

    localparam logic [31:0] RESET_XSP = 32'h0000_0100; // stack pointer after reset
    localparam logic [1:0]  PTR_XSP   = 2'd3;          // xsp slot in the pointer file
    localparam logic [7:0]  DMP_SR_HI = 8'd80;         // dump address, sr high byte
    localparam logic [7:0]  DMP_SR_LO = 8'd81;         // dump address, sr low byte (flags)

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        WORD = 2'd1,
        LONG = 2'd2
    } size_e;

    // opcode lives in md[31:28]
    typedef enum logic [3:0] {
        LDI  = 4'h0,
        MOV  = 4'h1,
        ADD  = 4'h2,
        SUB  = 4'h3,
        AND  = 4'h4,
        OR   = 4'h5,
        XOR  = 4'h6,
        CP   = 4'h7,
        SRFP = 4'h8,
        EXFF = 4'h9,
        JP   = 4'ha,
        NOP  = 4'hf
    } insn_op_e;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0, // rslt = op1
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {RMUX_SRC, RMUX_DST, RMUX_IMM, RMUX_ZERO} rmux_e;
    typedef enum logic [1:0] {RAL_NONE, RAL_SRC, RAL_DST, RAL_BOTH} ral_e;
    typedef enum logic [1:0] {OPND_NONE, OPND_LD0, OPND_LD1} opnd_e;
    typedef enum logic [1:0] {LD_NONE, LD_DST, LD_RFP, LD_PC} ld_e;

    typedef enum logic [2:0] {
        CC_KEEP      = 3'd0,
        CC_ARITH_ADD = 3'd1,
        CC_ARITH_SUB = 3'd2,
        CC_LOGIC_H1  = 3'd3, // and
        CC_LOGIC_H0  = 3'd4  // or, xor
    } cc_e;

    typedef struct packed {
        logic    inc_pc;
        logic    fetch;    // md <= din
        logic    exff;     // swap main and alternate flags
        size_e   size;
        alu_op_e alu_op;
        rmux_e   rmux_sel;
        ral_e    ral_sel;
        opnd_e   opnd_sel;
        ld_e     ld_sel;
        cc_e     cc_sel;
    } ucode_t;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic v;           // overflow or parity
        logic n;
        logic c;
    } alu_flags_t;

    typedef struct packed {
        insn_op_e    op;   // 31:28
        size_e       size; // 27:26
        logic [2:0]  dst;  // 25:23
        logic [2:0]  src;  // 22:20
        logic [3:0]  spare;
        logic [15:0] imm;
    } insn_t;

    // control word for a step that does nothing
    localparam ucode_t UCODE_IDLE = '{
        inc_pc:   1'b0,
        fetch:    1'b0,
        exff:     1'b0,
        size:     LONG,
        alu_op:   ALU_PASS,
        rmux_sel: RMUX_ZERO,
        ral_sel:  RAL_NONE,
        opnd_sel: OPND_NONE,
        ld_sel:   LD_NONE,
        cc_sel:   CC_KEEP
    };

endpackage

// File: hw/alu.sv
/*
 * Combinational ALU for byte, word and long operands.
 * Produces the sized result and every flag candidate, the register
 * bank picks which flags to keep.
 */
`timescale 1ns/100ps

module alu (
    input  logic [31:0]         op0,
    input  logic [31:0]         op1,
    input  cpu_pkg::alu_op_e    alu_op,
    input  cpu_pkg::size_e      size,
    output logic [31:0]         rslt,
    output cpu_pkg::alu_flags_t fo
);
    import cpu_pkg::*;

    logic [31:0] a, b;     // operands cut to size
    logic [32:0] sum;      // one extra bit for the long carry
    logic [4:0]  nib;      // low nibble, for half carry
    logic [31:0] raw;
    logic        is_sub, is_arith;
    logic        a_msb, b_msb, r_msb, cy;

    function automatic logic msb_at(input logic [31:0] x, input size_e sz);
        case (sz)
            BYTE:    msb_at = x[7];
            WORD:    msb_at = x[15];
            default: msb_at = x[31];
        endcase
    endfunction

    always_comb begin
        case (size)
            BYTE: begin
                a = {24'd0, op0[7:0]};
                b = {24'd0, op1[7:0]};
            end
            WORD: begin
                a = {16'd0, op0[15:0]};
                b = {16'd0, op1[15:0]};
            end
            default: begin
                a = op0;
                b = op1;
            end
        endcase

        is_sub   = alu_op == ALU_SUB;
        is_arith = alu_op == ALU_ADD || alu_op == ALU_SUB;
        sum = is_sub ? {1'b0, a} - {1'b0, b} : {1'b0, a} + {1'b0, b};
        nib = is_sub ? {1'b0, a[3:0]} - {1'b0, b[3:0]} : {1'b0, a[3:0]} + {1'b0, b[3:0]};

        case (alu_op)
            ALU_ADD, ALU_SUB: raw = sum[31:0];
            ALU_AND:          raw = a & b;
            ALU_OR:           raw = a | b;
            ALU_XOR:          raw = a ^ b;
            default:          raw = b;
        endcase

        // carry or borrow taken just above the top bit
        case (size)
            BYTE: begin
                rslt = {24'd0, raw[7:0]};
                cy   = sum[8];
            end
            WORD: begin
                rslt = {16'd0, raw[15:0]};
                cy   = sum[16];
            end
            default: begin
                rslt = raw;
                cy   = sum[32];
            end
        endcase

        a_msb = msb_at(a, size);
        b_msb = msb_at(b, size);
        r_msb = msb_at(rslt, size);

        fo.s = r_msb;
        fo.z = rslt == 32'd0;
        fo.n = is_sub;
        if (is_arith) begin
            fo.h = nib[4];
            fo.v = (is_sub ? a_msb != b_msb : a_msb == b_msb) && r_msb != a_msb;
            fo.c = cy;
        end else begin
            fo.h = alu_op == ALU_AND;
            fo.v = ~^rslt[7:0];   // even parity
            fo.c = 1'b0;
        end
    end

endmodule

// File: hw/ucode_seq.sv
/*
 * Instruction sequencer. Every instruction runs fetch, decode, operand
 * and execute, one enabled cycle each, and the opcode in md picks the
 * control word of each step. insn_done marks the end of an instruction.
 */
`timescale 1ns/100ps

module ucode_seq (
    input  logic            clk,
    input  logic            rst,
    input  logic            cen,
    input  cpu_pkg::insn_t  md,
    output cpu_pkg::ucode_t ctl,
    output logic            insn_done
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        DECODE  = 2'd1,
        OPERAND = 2'd2,
        EXECUTE = 2'd3
    } state_e;

    state_e state;
    logic   done_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= FETCH;
            done_q <= 1'b0;
        end else if (cen) begin
            done_q <= state == EXECUTE;
            case (state)
                FETCH:   state <= DECODE;
                DECODE:  state <= OPERAND;
                OPERAND: state <= EXECUTE;
                default: state <= FETCH;
            endcase
        end
    end

    // pulse only shows on an enabled cycle
    assign insn_done = done_q & cen;

    always_comb begin
        ctl      = UCODE_IDLE;
        ctl.size = md.size;
        if (md.op == SRFP || md.op == JP)
            ctl.size = LONG;              // imm goes through whole

        case (state)
            FETCH: begin
                ctl.fetch  = 1'b1;
                ctl.inc_pc = 1'b1;
            end
            DECODE: begin
                case (md.op)
                    LDI:                          ctl.ral_sel = RAL_DST;
                    MOV, ADD, SUB, AND, OR, XOR, CP: ctl.ral_sel = RAL_BOTH;
                    default: ;
                endcase
            end
            OPERAND: begin
                case (md.op)
                    LDI, SRFP, JP: begin
                        ctl.opnd_sel = OPND_LD1;
                        ctl.rmux_sel = RMUX_IMM;
                    end
                    MOV, ADD, SUB, AND, OR, XOR, CP: begin
                        ctl.opnd_sel = OPND_LD1;
                        ctl.rmux_sel = RMUX_SRC;
                    end
                    default: ;
                endcase
            end
            default: begin
                case (md.op)
                    LDI, MOV: ctl.ld_sel = LD_DST;
                    ADD: begin
                        ctl.alu_op = ALU_ADD;
                        ctl.ld_sel = LD_DST;
                        ctl.cc_sel = CC_ARITH_ADD;
                    end
                    SUB: begin
                        ctl.alu_op = ALU_SUB;
                        ctl.ld_sel = LD_DST;
                        ctl.cc_sel = CC_ARITH_SUB;
                    end
                    CP: begin
                        ctl.alu_op = ALU_SUB;    // flags only
                        ctl.cc_sel = CC_ARITH_SUB;
                    end
                    AND: begin
                        ctl.alu_op = ALU_AND;
                        ctl.ld_sel = LD_DST;
                        ctl.cc_sel = CC_LOGIC_H1;
                    end
                    OR: begin
                        ctl.alu_op = ALU_OR;
                        ctl.ld_sel = LD_DST;
                        ctl.cc_sel = CC_LOGIC_H0;
                    end
                    XOR: begin
                        ctl.alu_op = ALU_XOR;
                        ctl.ld_sel = LD_DST;
                        ctl.cc_sel = CC_LOGIC_H0;
                    end
                    SRFP:    ctl.ld_sel = LD_RFP;
                    JP:      ctl.ld_sel = LD_PC;
                    EXFF:    ctl.exff   = 1'b1;
                    default: ;
                endcase
            end
        endcase
    end

endmodule

// File: hw/reg_bank.sv
/*
 * Register bank of the core: banked accumulators, shared pointers,
 * address and operand latches, flags with alternate set, rfp, pc and md.
 * Driven by one control word per enabled cycle from the sequencer.
 * The dump port reads any register byte or the status register.
 */
`timescale 1ns/100ps

module reg_bank (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [31:0]         din,
    input  cpu_pkg::ucode_t     ctl,
    input  logic [31:0]         rslt,
    input  cpu_pkg::alu_flags_t fi,
    output logic [31:0]         md,
    output logic [23:0]         pc,
    output logic [31:0]         op0,
    output logic [31:0]         op1,
    output logic [7:0]          flags,
    input  logic [7:0]          dmp_addr,
    output logic [7:0]          dmp_dout
);
    import cpu_pkg::*;

    logic [31:0] accs [0:15];   // four banks of xwa, xbc, xde, xhl
    logic [31:0] ptrs [0:3];    // xix, xiy, xiz, xsp
    logic [4:0]  src, dst;      // RALs, {is_ptr, index}
    logic [1:0]  rfp;
    alu_flags_t  f, f_alt;
    insn_t       ins;
    logic [15:0] sr;
    logic [31:0] src_val, dst_val, rmux;
    logic [31:0] dmp_reg;

    // r3 code to latch address, codes 4..7 ignore the bank
    function automatic logic [4:0] r3_addr(input logic [2:0] code, input logic [1:0] bank);
        r3_addr = code[2] ? {1'b1, 2'b00, code[1:0]} : {1'b0, bank, code[1:0]};
    endfunction

    function automatic logic [31:0] size_mask(input logic [31:0] x, input size_e sz);
        case (sz)
            BYTE:    size_mask = {24'd0, x[7:0]};
            WORD:    size_mask = {16'd0, x[15:0]};
            default: size_mask = x;
        endcase
    endfunction

    // partial write keeps the upper bits of the old value
    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] val,
                                          input size_e sz);
        case (sz)
            BYTE:    merge = {old[31:8], val[7:0]};
            WORD:    merge = {old[31:16], val[15:0]};
            default: merge = val;
        endcase
    endfunction

    assign ins   = md;
    assign flags = {f.s, f.z, 1'b0, f.h, 1'b0, f.v, f.n, f.c};
    assign sr    = {1'b1, 3'b111, 2'b10, rfp, flags}; // iff fixed at 7

    always_comb begin
        src_val = size_mask(src[4] ? ptrs[src[1:0]] : accs[src[3:0]], ctl.size);
        dst_val = size_mask(dst[4] ? ptrs[dst[1:0]] : accs[dst[3:0]], ctl.size);
        case (ctl.rmux_sel)
            RMUX_SRC: rmux = src_val;
            RMUX_DST: rmux = dst_val;
            RMUX_IMM: rmux = size_mask({16'd0, ins.imm}, ctl.size); // zero extended
            default:  rmux = '0;
        endcase
    end

    // register dump, status register first
    assign dmp_reg  = dmp_addr[7:6] != 2'b00 ? ptrs[dmp_addr[3:2]] : accs[dmp_addr[5:2]];
    assign dmp_dout = dmp_addr == DMP_SR_HI ? sr[15:8] :
                      dmp_addr == DMP_SR_LO ? sr[7:0]  :
                                              dmp_reg[{dmp_addr[1:0], 3'b000} +: 8];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                accs[i] <= '0;
            end
            for (int j = 0; j < 3; j++) begin
                ptrs[j] <= '0;
            end
            ptrs[PTR_XSP] <= RESET_XSP;
            src   <= '0;
            dst   <= '0;
            rfp   <= '0;
            pc    <= '0;
            md    <= '0;
            op0   <= '0;
            op1   <= '0;
            f     <= '0;
            f_alt <= '0;
        end else if (cen) begin
            if (ctl.fetch)
                md <= din;
            if (ctl.inc_pc)
                pc <= pc + 24'd1;
            case (ctl.ral_sel)
                RAL_SRC:  src <= r3_addr(ins.src, rfp);
                RAL_DST:  dst <= r3_addr(ins.dst, rfp);
                RAL_BOTH: begin
                    src <= r3_addr(ins.src, rfp);
                    dst <= r3_addr(ins.dst, rfp);
                end
                default: ;
            endcase
            case (ctl.opnd_sel)
                OPND_LD0: op0 <= dst_val;
                OPND_LD1: begin
                    op0 <= dst_val;     // destination side
                    op1 <= rmux;        // source or immediate
                end
                default: ;
            endcase
            case (ctl.ld_sel)
                LD_DST: begin
                    if (dst[4])
                        ptrs[dst[1:0]] <= merge(ptrs[dst[1:0]], rslt, ctl.size);
                    else
                        accs[dst[3:0]] <= merge(accs[dst[3:0]], rslt, ctl.size);
                end
                LD_RFP:  rfp <= rslt[1:0];
                LD_PC:   pc  <= rslt[23:0];
                default: ;
            endcase
            if (ctl.exff) begin
                f     <= f_alt;
                f_alt <= f;
            end
            case (ctl.cc_sel)
                CC_ARITH_ADD: f <= '{s: fi.s, z: fi.z, h: fi.h, v: fi.v, n: 1'b0, c: fi.c};
                CC_ARITH_SUB: f <= '{s: fi.s, z: fi.z, h: fi.h, v: fi.v, n: 1'b1, c: fi.c};
                CC_LOGIC_H1:  f <= '{s: fi.s, z: fi.z, h: 1'b1, v: fi.v, n: 1'b0, c: 1'b0};
                CC_LOGIC_H0:  f <= '{s: fi.s, z: fi.z, h: 1'b0, v: fi.v, n: 1'b0, c: 1'b0};
                default: ;
            endcase
        end
    end

endmodule

// File: hw/cpu_core.sv
/*
 * Top level of the reduced core. Joins the sequencer, the register bank
 * and the ALU. Instruction memory sits outside, addressed by mem_addr
 * and answering on din in the same cycle.
 */
`timescale 1ns/100ps

module cpu_core (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [31:0] din,
    output logic [23:0] mem_addr,
    input  logic [7:0]  dmp_addr,
    output logic [7:0]  dmp_dout,
    output logic [7:0]  flags,
    output logic        insn_done
);
    import cpu_pkg::*;

    ucode_t      ctl;
    alu_flags_t  alu_fl;
    logic [31:0] md;
    logic [31:0] op0, op1, rslt;

    ucode_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .md        (md),
        .ctl       (ctl),
        .insn_done (insn_done)
    );

    reg_bank u_regs (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .din      (din),
        .ctl      (ctl),
        .rslt     (rslt),
        .fi       (alu_fl),
        .md       (md),
        .pc       (mem_addr),  // pc doubles as the fetch address
        .op0      (op0),
        .op1      (op1),
        .flags    (flags),
        .dmp_addr (dmp_addr),
        .dmp_dout (dmp_dout)
    );

    alu u_alu (
        .op0    (op0),
        .op1    (op1),
        .alu_op (ctl.alu_op),
        .size   (ctl.size),
        .rslt   (rslt),
        .fo     (alu_fl)
    );

endmodule

// File: verification/cpu_core_props.sv
/*
 * Concurrent assertions on the cpu_core strobes, bound into every
 * cpu_core instance. fail_cnt counts assertion failures.
 */
`timescale 1ns/100ps

module cpu_core_props (
    input logic        clk,
    input logic        rst,
    input logic        cen,
    input logic        insn_done,
    input logic [23:0] mem_addr
);
    int unsigned fail_cnt = 0;

    // a single pulse per instruction
    assert property (@(posedge clk) disable iff (rst) insn_done |=> !insn_done)
        else begin
            fail_cnt++;
            $error("insn_done high for two cycles in a row");
        end

    assert property (@(posedge clk) disable iff (rst) !cen |-> !insn_done)
        else begin
            fail_cnt++;
            $error("insn_done high while cen is low");
        end

    assert property (@(posedge clk) $fell(rst) |-> mem_addr == 24'd0)
        else begin
            fail_cnt++;
            $error("mem_addr not zero after reset");
        end

endmodule

bind cpu_core cpu_core_props props_i (
    .clk       (clk),
    .rst       (rst),
    .cen       (cen),
    .insn_done (insn_done),
    .mem_addr  (mem_addr)
);

// File: verification/tb_cpu_core.sv
/*
 * Directed testbench for cpu_core. Holds the program memory, runs one task
 * per behavior (reset and LDI, arithmetic, logic, banks and EXFF, random cen,
 * JP) and checks registers through the dump port, the flags and mem_addr.
 */
`timescale 1ns/100ps

module tb_cpu_core;
    import cpu_pkg::*;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [31:0] din;
    logic [23:0] mem_addr;
    logic [7:0]  dmp_addr;
    logic [7:0]  dmp_dout;
    logic [7:0]  flags;
    logic        insn_done;

    logic [31:0] prog [0:255];   // instruction memory indexed by mem_addr[7:0]
    logic        rand_cen;
    integer      seed;
    int unsigned errors;
    int unsigned checks;
    int unsigned cycles;

    cpu_core cpu_core_i (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .din       (din),
        .mem_addr  (mem_addr),
        .dmp_addr  (dmp_addr),
        .dmp_dout  (dmp_dout),
        .flags     (flags),
        .insn_done (insn_done)
    );

    assign din = prog[mem_addr[7:0]]; // same-cycle read

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (rand_cen)
            cen <= ($random(seed) & 3) != 0; // high about 3 cycles in 4
        else
            cen <= 1'b1;
    end

    // 63 instructions x 4 cycles x 3 for random cen plus margin for resets and dumps
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 63 * 4 * 3 + 2000) begin
            $display("timeout, the run did not finish after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // packs op size dst src spare imm into one word
    function automatic logic [31:0] enc(input insn_op_e op, input size_e sz,
                                        input logic [2:0] d, input logic [2:0] s,
                                        input logic [15:0] imm);
        enc = {op, sz, d, s, 4'h0, imm};
    endfunction

    // status low byte is s z 0 h 0 v n c
    function automatic logic [7:0] mk_flags(input alu_flags_t f);
        mk_flags = {f.s, f.z, 1'b0, f.h, 1'b0, f.v, f.n, f.c};
    endfunction

    task automatic clear_prog();
        for (int i = 0; i < 256; i++) begin
            prog[i] = {NOP, 12'h000, 8'h00, i[7:0]}; // address kept in imm
        end
    endtask

    task automatic put(input logic [7:0] a, input logic [31:0] w);
        prog[a] = w;
    endtask

    task automatic do_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic wait_done(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            if (insn_done)
                seen++;
        end
    endtask

    task automatic read_byte(input logic [7:0] a, output logic [7:0] b);
        @(posedge clk);
        dmp_addr <= a;
        @(negedge clk);
        b = dmp_dout;
    endtask

    task automatic check_reg(input logic [2:0] code, input logic [1:0] bank,
                             input logic [31:0] exp);
        logic [7:0]  base;
        logic [7:0]  b;
        logic [31:0] got;
        // pointers sit at 0x40 + 4*index and accumulators at 4*(bank*4 + code)
        base = code[2] ? {4'h4, code[1:0], 2'b00} : {2'b00, bank, code[1:0], 2'b00};
        for (int k = 0; k < 4; k++) begin
            read_byte(base + k[7:0], b);
            got[8*k +: 8] = b;
        end
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR @%0t: reg code %0d bank %0d is %h, expected %h",
                     $time, code, bank, got, exp);
        end
    endtask

    task automatic check_flags(input logic [7:0] got, input logic [7:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR @%0t: %s status %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input logic [23:0] exp);
        checks++;
        if (mem_addr !== exp) begin
            errors++;
            $display("ERR @%0t: mem_addr %h, expected %h", $time, mem_addr, exp);
        end
    endtask

    task automatic test_reset_ldi();
        logic [7:0]  b;
        logic [15:0] imm;
        clear_prog();
        do_reset();
        @(negedge clk);
        check_addr(24'd0);
        for (int bk = 0; bk < 4; bk++) begin
            for (int c = 0; c < 4; c++) begin
                check_reg(c[2:0], bk[1:0], 32'd0);
            end
        end
        check_reg(3'd4, 2'd0, 32'd0);
        check_reg(3'd5, 2'd0, 32'd0);
        check_reg(3'd6, 2'd0, 32'd0);
        check_reg(3'd7, 2'd0, RESET_XSP);
        read_byte(DMP_SR_HI, b);
        check_flags(b, {1'b1, 3'b111, 2'b10, 2'd0}, "sr high after reset");
        read_byte(DMP_SR_LO, b);
        check_flags(b, 8'h00, "sr low after reset");

        for (int k = 0; k < 8; k++) begin
            imm = 16'h1111 * k[15:0] + 16'h1111;
            put(k[7:0], enc(LDI, LONG, k[2:0], 3'd0, imm));
        end
        do_reset();
        wait_done(8);
        check_addr(24'd8);
        check_flags(flags, 8'h00, "ldi keeps flags");
        for (int k = 0; k < 8; k++) begin
            imm = 16'h1111 * k[15:0] + 16'h1111;
            check_reg(k[2:0], 2'd0, {16'd0, imm});
        end
    endtask

    task automatic load_arith_prog();
        clear_prog();
        put(0, enc(LDI, LONG, 3'd1, 3'd0, 16'h0001));  // xbc = 1
        put(1, enc(SUB, LONG, 3'd0, 3'd1, 16'h0));     // xwa = 0 - 1
        put(2, enc(MOV, LONG, 3'd2, 3'd0, 16'h0));     // xde = xwa
        put(3, enc(ADD, LONG, 3'd2, 3'd1, 16'h0));     // wraps to zero
        put(4, enc(LDI, BYTE, 3'd0, 3'd0, 16'h007f));
        put(5, enc(ADD, BYTE, 3'd0, 3'd1, 16'h0));     // 7f + 1
        put(6, enc(SUB, BYTE, 3'd0, 3'd1, 16'h0));     // 80 - 1
        put(7, enc(MOV, LONG, 3'd4, 3'd0, 16'h0));
        put(8, enc(LDI, WORD, 3'd4, 3'd0, 16'h8000));
        put(9, enc(ADD, WORD, 3'd4, 3'd4, 16'h0));     // 8000 + 8000
        put(10, enc(SUB, WORD, 3'd5, 3'd1, 16'h0));    // 0 - 1
        put(11, enc(ADD, LONG, 3'd7, 3'd7, 16'h0));    // xsp doubles
    endtask

    task automatic check_arith_regs();
        check_reg(3'd0, 2'd0, 32'hffff_ff7f);  // upper bits kept by byte ops
        check_reg(3'd1, 2'd0, 32'h0000_0001);
        check_reg(3'd2, 2'd0, 32'h0000_0000);
        check_reg(3'd3, 2'd0, 32'h0000_0000);
        check_reg(3'd4, 2'd0, 32'hffff_0000);  // upper word kept
        check_reg(3'd5, 2'd0, 32'h0000_ffff);
        check_reg(3'd6, 2'd0, 32'h0000_0000);
        check_reg(3'd7, 2'd0, 32'h0000_0200);
    endtask

    // flag patterns below are s z h v n c
    task automatic test_arith();
        load_arith_prog();
        do_reset();
        wait_done(2);
        check_flags(flags, mk_flags(6'b101011), "sub long borrow");
        wait_done(1);
        check_flags(flags, mk_flags(6'b101011), "mov keeps flags");
        wait_done(1);
        check_flags(flags, mk_flags(6'b011001), "add long carry");
        wait_done(2);
        check_flags(flags, mk_flags(6'b101100), "add byte overflow");
        wait_done(1);
        check_flags(flags, mk_flags(6'b001110), "sub byte overflow");
        wait_done(2);
        check_flags(flags, mk_flags(6'b001110), "ldi keeps flags");
        wait_done(1);
        check_flags(flags, mk_flags(6'b010101), "add word carry");
        wait_done(1);
        check_flags(flags, mk_flags(6'b101011), "sub word borrow");
        wait_done(1);
        check_flags(flags, mk_flags(6'b000000), "add long clean");
        check_arith_regs();
    endtask

    task automatic test_logic();
        clear_prog();
        put(0, enc(LDI, LONG, 3'd0, 3'd0, 16'h00f0));
        put(1, enc(LDI, LONG, 3'd1, 3'd0, 16'h003c));
        put(2, enc(MOV, LONG, 3'd2, 3'd0, 16'h0));
        put(3, enc(AND, BYTE, 3'd2, 3'd1, 16'h0));     // 30 with even parity
        put(4, enc(MOV, LONG, 3'd3, 3'd0, 16'h0));
        put(5, enc(OR, WORD, 3'd3, 3'd1, 16'h0));      // fc
        put(6, enc(MOV, LONG, 3'd4, 3'd0, 16'h0));
        put(7, enc(XOR, LONG, 3'd4, 3'd4, 16'h0));     // zero
        put(8, enc(LDI, LONG, 3'd5, 3'd0, 16'h8001));
        put(9, enc(AND, WORD, 3'd5, 3'd5, 16'h0));     // odd parity and sign set
        put(10, enc(CP, BYTE, 3'd0, 3'd1, 16'h0));
        put(11, enc(CP, LONG, 3'd1, 3'd0, 16'h0));
        put(12, enc(CP, WORD, 3'd0, 3'd0, 16'h0));     // equal
        do_reset();
        wait_done(4);
        check_flags(flags, mk_flags(6'b001100), "and byte");
        wait_done(2);
        check_flags(flags, mk_flags(6'b000100), "or word");
        wait_done(2);
        check_flags(flags, mk_flags(6'b010100), "xor long zero");
        wait_done(2);
        check_flags(flags, mk_flags(6'b101000), "and word odd parity");
        wait_done(1);
        check_flags(flags, mk_flags(6'b101010), "cp byte");
        wait_done(1);
        check_flags(flags, mk_flags(6'b100011), "cp long borrow");
        wait_done(1);
        check_flags(flags, mk_flags(6'b010010), "cp word equal");
        check_reg(3'd0, 2'd0, 32'h0000_00f0);  // cp leaves both sides alone
        check_reg(3'd1, 2'd0, 32'h0000_003c);
        check_reg(3'd2, 2'd0, 32'h0000_0030);
        check_reg(3'd3, 2'd0, 32'h0000_00fc);
        check_reg(3'd4, 2'd0, 32'h0000_0000);
        check_reg(3'd5, 2'd0, 32'h0000_8001);
    endtask

    task automatic test_banks();
        logic [7:0] b;
        clear_prog();
        put(0, enc(LDI, LONG, 3'd0, 3'd0, 16'h0a00));
        put(1, enc(LDI, LONG, 3'd4, 3'd0, 16'h1234));
        put(2, enc(SRFP, LONG, 3'd0, 3'd0, 16'h0005));  // only bits 1:0 count
        put(3, enc(LDI, LONG, 3'd0, 3'd0, 16'h0a01));
        put(4, enc(LDI, LONG, 3'd3, 3'd0, 16'h0d01));
        put(5, enc(SRFP, LONG, 3'd0, 3'd0, 16'h0002));
        put(6, enc(LDI, LONG, 3'd0, 3'd0, 16'h0a02));
        put(7, enc(SRFP, LONG, 3'd0, 3'd0, 16'h0003));
        put(8, enc(LDI, LONG, 3'd0, 3'd0, 16'h0a03));
        put(9, enc(LDI, LONG, 3'd4, 3'd0, 16'h5678));   // pointer shared
        put(10, enc(SUB, BYTE, 3'd1, 3'd0, 16'h0));     // 0 - 3 in bank 3
        put(11, enc(EXFF, LONG, 3'd0, 3'd0, 16'h0));
        put(12, enc(EXFF, LONG, 3'd0, 3'd0, 16'h0));
        do_reset();
        wait_done(11);
        check_flags(flags, mk_flags(6'b101011), "sub byte in bank 3");
        wait_done(1);
        check_flags(flags, 8'h00, "alternate set after exff");
        wait_done(1);
        check_flags(flags, mk_flags(6'b101011), "restored after two exff");
        check_reg(3'd0, 2'd0, 32'h0000_0a00);
        check_reg(3'd0, 2'd1, 32'h0000_0a01);
        check_reg(3'd0, 2'd2, 32'h0000_0a02);
        check_reg(3'd0, 2'd3, 32'h0000_0a03);
        check_reg(3'd3, 2'd1, 32'h0000_0d01);
        check_reg(3'd3, 2'd0, 32'h0000_0000);
        check_reg(3'd1, 2'd3, 32'h0000_00fd);
        check_reg(3'd1, 2'd0, 32'h0000_0000);
        check_reg(3'd4, 2'd0, 32'h0000_5678);
        read_byte(DMP_SR_HI, b);
        check_flags(b, {1'b1, 3'b111, 2'b10, 2'd3}, "sr high with rfp 3");
        read_byte(DMP_SR_LO, b);
        check_flags(b, mk_flags(6'b101011), "sr low");
    endtask

    task automatic test_random_cen();
        rand_cen = 1'b1;
        load_arith_prog();
        do_reset();
        for (int k = 1; k <= 12; k++) begin
            wait_done(1);
            check_addr(k[23:0]);  // one pulse per fetched word
        end
        check_flags(flags, 8'h00, "random cen final flags");
        check_arith_regs();
        rand_cen = 1'b0;
    endtask

    task automatic test_jump();
        clear_prog();
        put(8'h00, enc(LDI, LONG, 3'd0, 3'd0, 16'h0001));
        put(8'h01, enc(JP, LONG, 3'd0, 3'd0, 16'h0040));
        put(8'h02, enc(LDI, LONG, 3'd0, 3'd0, 16'h0bad)); // skipped
        put(8'h40, enc(ADD, LONG, 3'd0, 3'd0, 16'h0));
        put(8'h41, enc(JP, LONG, 3'd0, 3'd0, 16'h0010));
        put(8'h10, enc(LDI, LONG, 3'd1, 3'd0, 16'h0777));
        do_reset();
        wait_done(1);
        check_addr(24'h000001);
        wait_done(1);
        check_addr(24'h000040);
        wait_done(1);
        check_addr(24'h000041);
        wait_done(1);
        check_addr(24'h000010);
        wait_done(1);
        check_addr(24'h000011);
        check_flags(flags, 8'h00, "add after jump");
        check_reg(3'd0, 2'd0, 32'h0000_0002);
        check_reg(3'd1, 2'd0, 32'h0000_0777);
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        cen      = 1'b1;
        dmp_addr = 8'd0;
        rand_cen = 1'b0;
        seed     = 53215;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        clear_prog();

        test_reset_ldi();
        test_arith();
        test_logic();
        test_banks();
        test_random_cen();
        test_jump();

        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, cpu_core_i.props_i.fail_cnt);
        if (errors == 0 && cpu_core_i.props_i.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/cpu_pkg.sv
hw/alu.sv
hw/ucode_seq.sv
hw/reg_bank.sv
hw/cpu_core.sv
verification/cpu_core_props.sv
verification/tb_cpu_core.sv

// File: Makefile
# Verilator build for the cpu_core testbench

TOP = tb_cpu_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
